// ==== common/arm_params.svh ====
/*
   ARM core parameters
   Architectural widths, register indices and PC offsets
*/
`ifndef ARM_PARAMS_SVH
`define ARM_PARAMS_SVH

// Data and address width
`define ARM_XLEN 32

// Architectural registers, R0 to R15
`define ARM_NREGS 16

// Register that reads as PC+8
`define ARM_PC_REG 15

// Byte step to the next instruction
`define ARM_PC_STEP 4

// R15 read-ahead, two instructions past the current one
`define ARM_PC_AHEAD 8

`endif

// ==== common/arm_pkg.sv ====
/*
   ARM core types
   Opcodes, instruction classes, flags and control bundles
*/
`include "arm_params.svh"

package arm_pkg;

   typedef logic [`ARM_XLEN-1:0] word_t;
   typedef logic [$clog2(`ARM_NREGS)-1:0] regIdx_t;

   typedef enum logic [2:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_ORR, ALU_EOR, ALU_MOV
   } aluOp_t;

   // Matches op bits 27:26
   typedef enum logic [1:0] {
      CLS_DATA   = 2'b00,
      CLS_MEM    = 2'b01,
      CLS_BRANCH = 2'b10
   } instrClass_t;

   typedef enum logic [3:0] {
      COND_EQ, COND_NE, COND_CS, COND_CC, COND_MI, COND_PL, COND_VS, COND_VC,
      COND_HI, COND_LS, COND_GE, COND_LT, COND_GT, COND_LE, COND_AL
   } condCode_t;

   typedef enum logic [1:0] {
      IMM_DP8, IMM_MEM12, IMM_BR24
   } immKind_t;

   typedef struct packed {
      logic neg;
      logic zero;
      logic carry;
      logic overflow;
   } flags_t;

   // Raw decoder output, before condition and stall gating
   typedef struct packed {
      logic regWrite;
      logic memAccess;
      logic memWrite;
      logic branch;
      logic flagWriteNZ;
      logic flagWriteCV;
      immKind_t immKind;
      logic useImm;
      logic memToReg;
      logic storeSrcRd;   // Port B reads rd
      aluOp_t aluOp;
   } ctrl_t;

   // Gated state-update enables
   typedef struct packed {
      logic regWrite;
      logic memStrobe;
      logic memWrite;
      logic pcLoad;
      logic pcSrc;        // Take branch target
   } writeEn_t;

   typedef struct packed {
      word_t addr;
      word_t writeData;
      logic strobe;
      logic write;
   } dmemReq_t;

endpackage

// ==== control/instrDecoder.sv ====
/*
   Instruction decoder
   Maps class and funct bits to raw control and an ALU opcode
*/
module instrDecoder (
   input  arm_pkg::word_t instr,
   output arm_pkg::ctrl_t ctrl
);
   import arm_pkg::*;

   instrClass_t cls;
   logic [5:0] funct;
   logic sBit;
   aluOp_t dpOp;
   logic dpValid;
   logic dpWrite;

   assign cls   = instrClass_t'(instr[27:26]);
   assign funct = instr[25:20];
   assign sBit  = funct[0];

   // Data-processing opcode
   always_comb begin
      dpOp    = ALU_ADD;
      dpValid = 1'b1;
      dpWrite = 1'b1;
      case (funct[4:1])
         4'b0100: dpOp = ALU_ADD;
         4'b0010: dpOp = ALU_SUB;
         4'b0000: dpOp = ALU_AND;
         4'b1100: dpOp = ALU_ORR;
         4'b0001: dpOp = ALU_EOR;
         4'b1101: dpOp = ALU_MOV;
         4'b1010: begin           // CMP, flags only
            dpOp    = ALU_SUB;
            dpWrite = 1'b0;
            dpValid = sBit;
         end
         default: dpValid = 1'b0;   // Unsupported, no effect
      endcase
   end

   always_comb begin
      ctrl         = '0;
      ctrl.aluOp   = ALU_ADD;
      ctrl.immKind = IMM_DP8;
      case (cls)
         CLS_DATA: begin
            ctrl.regWrite    = dpValid & dpWrite;
            ctrl.flagWriteNZ = dpValid & sBit;
            ctrl.flagWriteCV = dpValid & sBit & (dpOp == ALU_ADD || dpOp == ALU_SUB);
            ctrl.useImm      = funct[5];
            ctrl.aluOp       = dpOp;
         end
         CLS_MEM: begin
            // L bit picks load over store, address is base plus offset
            ctrl.memAccess  = 1'b1;
            ctrl.memWrite   = ~sBit;
            ctrl.regWrite   = sBit;
            ctrl.memToReg   = sBit;
            ctrl.storeSrcRd = 1'b1;
            ctrl.useImm     = 1'b1;
            ctrl.immKind    = IMM_MEM12;
         end
         CLS_BRANCH: begin
            ctrl.branch  = ~instr[24];   // BL not supported
            ctrl.immKind = IMM_BR24;
         end
         default: ;
      endcase
   end

endmodule

// ==== control/condUnit.sv ====
/*
   Condition unit
   NZCV flag register and the condition check gating every state update
*/
module condUnit (
   input  logic clk,
   input  logic reset,
   input  arm_pkg::condCode_t cond,
   input  arm_pkg::ctrl_t ctrl,
   input  arm_pkg::flags_t aluFlags,
   input  logic pcReady,
   output arm_pkg::writeEn_t wen
);
   import arm_pkg::*;

   logic [1:0] nzReg;
   logic [1:0] cvReg;
   flags_t flags;
   logic condEx;
   logic commit;
   logic ge;

   assign flags = {nzReg, cvReg};
   assign ge    = (flags.neg == flags.overflow);

   always_comb begin
      case (cond)
         COND_EQ: condEx = flags.zero;
         COND_NE: condEx = ~flags.zero;
         COND_CS: condEx = flags.carry;
         COND_CC: condEx = ~flags.carry;
         COND_MI: condEx = flags.neg;
         COND_PL: condEx = ~flags.neg;
         COND_VS: condEx = flags.overflow;
         COND_VC: condEx = ~flags.overflow;
         COND_HI: condEx = flags.carry & ~flags.zero;
         COND_LS: condEx = ~flags.carry | flags.zero;
         COND_GE: condEx = ge;
         COND_LT: condEx = ~ge;
         COND_GT: condEx = ~flags.zero & ge;
         COND_LE: condEx = flags.zero | ~ge;
         COND_AL: condEx = 1'b1;
         default: condEx = 1'b0;   // 1111 never executes
      endcase
   end

   assign commit = pcReady & ~reset;

   // NZ and CV update as separate groups
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         nzReg <= '0;
         cvReg <= '0;
      end else begin
         if (commit & condEx & ctrl.flagWriteNZ) nzReg <= {aluFlags.neg, aluFlags.zero};
         if (commit & condEx & ctrl.flagWriteCV) cvReg <= {aluFlags.carry, aluFlags.overflow};
      end
   end

   assign wen.regWrite  = ctrl.regWrite & condEx & commit;
   assign wen.memStrobe = ctrl.memAccess & condEx & commit;
   assign wen.memWrite  = ctrl.memWrite & condEx & commit;
   assign wen.pcLoad    = commit;   // PC advances on every ready cycle
   assign wen.pcSrc     = ctrl.branch & condEx & commit;

endmodule

// ==== datapath/alu.sv ====
/*
   ALU
   Six operations with NZCV flags, C and V only for add and subtract
*/
`include "arm_params.svh"

module alu (
   input  arm_pkg::word_t a,
   input  arm_pkg::word_t b,
   input  arm_pkg::aluOp_t op,
   output arm_pkg::word_t result,
   output arm_pkg::flags_t flags
);
   import arm_pkg::*;

   localparam int Msb = `ARM_XLEN - 1;

   logic isSub;
   logic isArith;
   word_t bIn;
   logic [`ARM_XLEN:0] sum;

   assign isSub   = (op == ALU_SUB);
   assign isArith = (op == ALU_ADD) || isSub;

   // Subtract as a + ~b + 1, carry out means no borrow
   assign bIn = isSub ? ~b : b;
   assign sum = {1'b0, a} + {1'b0, bIn} + {{`ARM_XLEN{1'b0}}, isSub};

   always_comb begin
      case (op)
         ALU_ADD: result = sum[Msb:0];
         ALU_SUB: result = sum[Msb:0];
         ALU_AND: result = a & b;
         ALU_ORR: result = a | b;
         ALU_EOR: result = a ^ b;
         ALU_MOV: result = b;
         default: result = '0;
      endcase
   end

   assign flags.neg   = result[Msb];
   assign flags.zero  = (result == '0);
   assign flags.carry = isArith & sum[`ARM_XLEN];
   // Operands of equal sign, result sign differs
   assign flags.overflow = isArith & ~(a[Msb] ^ bIn[Msb]) & (a[Msb] ^ sum[Msb]);

endmodule

// ==== datapath/regFile.sv ====
/*
   Register file
   Fifteen general registers, two read ports, R15 returns PC+8
*/
`include "arm_params.svh"

module regFile (
   input  logic clk,
   input  arm_pkg::regIdx_t readAddrA,
   input  arm_pkg::regIdx_t readAddrB,
   input  arm_pkg::regIdx_t writeAddr,
   input  arm_pkg::word_t writeData,
   input  logic writeEn,
   input  arm_pkg::word_t pcPlus8,
   output arm_pkg::word_t readDataA,
   output arm_pkg::word_t readDataB
);
   import arm_pkg::*;

   localparam regIdx_t PcIdx = regIdx_t'(`ARM_PC_REG);

   word_t regs [`ARM_NREGS-2:0];

   // R15 is not writable here
   always_ff @(posedge clk) begin
      if (writeEn && writeAddr != PcIdx) regs[writeAddr] <= writeData;
   end

   assign readDataA = (readAddrA == PcIdx) ? pcPlus8 : regs[readAddrA];
   assign readDataB = (readAddrB == PcIdx) ? pcPlus8 : regs[readAddrB];

endmodule

// ==== datapath/datapath.sv ====
/*
   Datapath
   PC register, immediate extension, operand and writeback selection,
   data-memory request forming
*/
`include "arm_params.svh"

module datapath (
   input  logic clk,
   input  logic reset,
   input  arm_pkg::word_t instr,
   input  arm_pkg::ctrl_t ctrl,
   input  arm_pkg::writeEn_t wen,
   output arm_pkg::word_t pc,
   output arm_pkg::flags_t aluFlags,
   output arm_pkg::dmemReq_t dmemReq,
   input  arm_pkg::word_t readData
);
   import arm_pkg::*;

   word_t pcPlus4;
   word_t pcPlus8;
   word_t branchTarget;
   word_t extImm;
   word_t srcA;
   word_t rdB;
   word_t srcB;
   word_t aluResult;
   word_t result;
   regIdx_t addrB;

   assign pcPlus4      = pc + word_t'(`ARM_PC_STEP);
   assign pcPlus8      = pc + word_t'(`ARM_PC_AHEAD);
   assign branchTarget = pcPlus8 + extImm;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) pc <= '0;
      else if (wen.pcLoad) pc <= wen.pcSrc ? branchTarget : pcPlus4;
   end

   always_comb begin
      case (ctrl.immKind)
         IMM_DP8:   extImm = {24'b0, instr[7:0]};
         IMM_MEM12: extImm = {20'b0, instr[11:0]};
         IMM_BR24:  extImm = {{6{instr[23]}}, instr[23:0], 2'b00};   // Word offset
         default:   extImm = '0;
      endcase
   end

   // Stores read rd on port B, ALU ops read rm
   assign addrB = ctrl.storeSrcRd ? instr[15:12] : instr[3:0];

   regFile rf (
      .clk(clk),
      .readAddrA(instr[19:16]),
      .readAddrB(addrB),
      .writeAddr(instr[15:12]),
      .writeData(result),
      .writeEn(wen.regWrite),
      .pcPlus8(pcPlus8),
      .readDataA(srcA),
      .readDataB(rdB)
   );

   assign srcB = ctrl.useImm ? extImm : rdB;

   alu alu (
      .a(srcA),
      .b(srcB),
      .op(ctrl.aluOp),
      .result(aluResult),
      .flags(aluFlags)
   );

   assign result = ctrl.memToReg ? readData : aluResult;

   assign dmemReq.addr      = aluResult;
   assign dmemReq.writeData = rdB;
   assign dmemReq.strobe    = wen.memStrobe;
   assign dmemReq.write     = wen.memWrite;

endmodule

// ==== rtl/armCore.sv ====
/*
   Single-cycle ARMv4 subset core
   Decoder and condition unit steer the datapath, one instruction per ready cycle
*/
module armCore (
   input  logic clk,
   input  logic reset,
   output arm_pkg::word_t pc,
   input  arm_pkg::word_t instr,
   output arm_pkg::dmemReq_t dmemReq,
   input  arm_pkg::word_t readData,
   input  logic pcReady
);
   import arm_pkg::*;

   ctrl_t ctrl;
   flags_t aluFlags;
   writeEn_t wen;

   instrDecoder decoder (
      .instr(instr),
      .ctrl(ctrl)
   );

   // Control beside the datapath it gates
   condUnit cond (
      .clk(clk),
      .reset(reset),
      .cond(condCode_t'(instr[31:28])),
      .ctrl(ctrl),
      .aluFlags(aluFlags),
      .pcReady(pcReady),
      .wen(wen)
   );

   datapath dp (
      .clk(clk),
      .reset(reset),
      .instr(instr),
      .ctrl(ctrl),
      .wen(wen),
      .pc(pc),
      .aluFlags(aluFlags),
      .dmemReq(dmemReq),
      .readData(readData)
   );

endmodule

// ==== test/armCore_properties.sv ====
/*
   Core port properties
   Strobe qualification and PC sequencing on the top-level ports
*/
module armCore_properties (
   input logic clk,
   input logic reset,
   input arm_pkg::word_t pc,
   input arm_pkg::dmemReq_t dmemReq,
   input logic pcReady
);
   import arm_pkg::*;

   int failures = 0;

   writeNeedsStrobe: assert property (@(posedge clk) disable iff (reset)
      dmemReq.write |-> dmemReq.strobe)
      else begin
         $error("Write asserted without strobe");
         failures++;
      end

   noStrobeStalled: assert property (@(posedge clk) disable iff (reset)
      !pcReady |-> !dmemReq.strobe)
      else begin
         $error("Strobe asserted while pcReady is low");
         failures++;
      end

   pcAligned: assert property (@(posedge clk) disable iff (reset)
      pc[1:0] == 2'b00)
      else begin
         $error("PC is not word aligned");
         failures++;
      end

   // No commit, so PC holds into the next cycle
   pcHoldsOnStall: assert property (@(posedge clk) disable iff (reset)
      !pcReady |=> $stable(pc))
      else begin
         $error("PC changed after a stalled cycle");
         failures++;
      end

endmodule

// ==== test/armCore_tb.sv ====
/*
   Testbench for the single-cycle ARM core
   Random program checked against an ISA reference model on every commit
*/
`include "arm_params.svh"

module armCore_tb;
   import arm_pkg::*;

   localparam int ProgLen = 96;
   localparam int Period = 8;
   localparam word_t LoopInstr = 32'hEAFFFFFE;   // B to itself
   // ADD, SUB, AND, ORR, EOR, MOV
   localparam logic [3:0] OpTable [6] = '{4'b0100, 4'b0010, 4'b0000, 4'b1100, 4'b0001, 4'b1101};

   logic clk = 1'b0;
   logic reset;
   logic pcReady;
   word_t pc;
   word_t instr;
   word_t readData;
   dmemReq_t dmemReq;

   word_t imem [128];
   word_t dmem [64];
   word_t mRegs [16];   // Model state
   word_t mMem [64];
   word_t mPc = '0;
   flags_t mFlags = '0;
   word_t checkPc;
   int loopHits = 0;

   armCore dut (.*);

   bind armCore armCore_properties props (.*);

   always #(Period / 2) clk = ~clk;

   // Instruction and data memories
   assign instr    = imem[pc[8:2]];
   assign readData = dmem[dmemReq.addr[7:2]];

   always @(posedge clk) begin
      if (dmemReq.strobe && dmemReq.write) dmem[dmemReq.addr[7:2]] <= dmemReq.writeData;
   end

   task automatic checkValue(input string name, input word_t expected, input word_t actual);
      if (actual !== expected) begin
         $display("Error: %s at pc %h expected %h actual %h", name, checkPc, expected, actual);
         $display("TEST FAILED");
         $fatal(1, "Stopping at first mismatch");
      end
   endtask

   function automatic logic condPass(input logic [3:0] cond, input flags_t f);
      case (cond)
         4'h0: return f.zero;
         4'h1: return !f.zero;
         4'h2: return f.carry;
         4'h3: return !f.carry;
         4'h4: return f.neg;
         4'h5: return !f.neg;
         4'h6: return f.overflow;
         4'h7: return !f.overflow;
         4'h8: return f.carry && !f.zero;
         4'h9: return !f.carry || f.zero;
         4'hA: return f.neg == f.overflow;
         4'hB: return f.neg != f.overflow;
         4'hC: return !f.zero && (f.neg == f.overflow);
         4'hD: return f.zero || (f.neg != f.overflow);
         4'hE: return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

   function automatic word_t readReg(input logic [3:0] idx);
      return (idx == 4'd15) ? mPc + `ARM_PC_AHEAD : mRegs[idx];
   endfunction

   // Runs one instruction on the model and returns the expected memory request
   function automatic dmemReq_t stepModel(input word_t ins);
      dmemReq_t req;
      logic pass;
      logic [3:0] opc;
      word_t a;
      word_t b;
      word_t res;
      word_t nextPc;
      req    = '0;
      pass   = condPass(ins[31:28], mFlags);
      opc    = ins[24:21];
      a      = readReg(ins[19:16]);
      nextPc = mPc + `ARM_PC_STEP;
      case (ins[27:26])
         2'b00: begin
            b = ins[25] ? {24'b0, ins[7:0]} : readReg(ins[3:0]);
            case (opc)
               4'b0100: res = a + b;
               4'b0010, 4'b1010: res = a - b;
               4'b0000: res = a & b;
               4'b1100: res = a | b;
               4'b0001: res = a ^ b;
               default: res = b;
            endcase
            if (pass && opc != 4'b1010) mRegs[ins[15:12]] = res;   // CMP keeps rd
            if (pass && ins[20]) begin
               mFlags.neg  = res[31];
               mFlags.zero = (res == '0);
               if (opc == 4'b0100) begin
                  mFlags.carry    = res < a;
                  mFlags.overflow = (a[31] == b[31]) && (res[31] != a[31]);
               end else if (opc == 4'b0010 || opc == 4'b1010) begin
                  mFlags.carry    = a >= b;   // No borrow
                  mFlags.overflow = (a[31] != b[31]) && (res[31] != a[31]);
               end
            end
         end
         2'b01: begin
            req.addr      = a + {20'b0, ins[11:0]};
            req.writeData = readReg(ins[15:12]);
            req.strobe    = pass;
            req.write     = pass && !ins[20];
            if (pass && ins[20]) mRegs[ins[15:12]] = mMem[req.addr[7:2]];
            else if (pass) mMem[req.addr[7:2]] = req.writeData;
         end
         default: if (pass) nextPc = mPc + `ARM_PC_AHEAD + int'(signed'(ins[23:0])) * 4;
      endcase
      mPc = nextPc;
      return req;
   endfunction

   task automatic genProgram();
      logic [3:0] cond;
      logic [3:0] rd;
      logic [3:0] rn;
      logic [3:0] opc;
      int maxOff;
      for (int i = 0; i < 128; i++) imem[i] = LoopInstr;
      // Every register gets a value and R13 stays zero as the memory base
      for (int i = 0; i < 15; i++)
         imem[i] = {4'hE, 3'b001, 4'b1101, 1'b0, 4'd0, 4'(i), 4'd0,
                    (i == 13) ? 8'd0 : 8'($urandom)};
      for (int i = 15; i < ProgLen - 1; i++) begin
         cond   = ($urandom % 2) ? 4'hE : 4'($urandom % 15);
         rd     = 4'($urandom % 13);
         rn     = 4'($urandom % 16);
         opc    = OpTable[$urandom % 6];
         maxOff = ProgLen - 3 - i;
         case ($urandom % 8)
            0, 1: imem[i] = {cond, 3'b001, opc, 1'($urandom), rn, rd, 4'd0, 8'($urandom)};
            2: imem[i] = {cond, 3'b000, opc, 1'($urandom), rn, rd, 8'd0, 4'($urandom)};
            3: imem[i] = {cond, 3'b001, 4'b1010, 1'b1, rn, 4'd0, 4'd0, 8'($urandom)};   // CMP
            4, 5: imem[i] = {cond, 8'b01011000, 4'd13, rd, 4'd0, 6'($urandom), 2'b00};
            6: imem[i] = {cond, 8'b01011001, 4'd13, rd, 4'd0, 6'($urandom), 2'b00};
            default: begin
               if (maxOff >= 0)
                  imem[i] = {cond, 4'b1010, 24'($urandom % ((maxOff < 3) ? maxOff + 1 : 4))};
               else
                  imem[i] = {cond, 3'b001, 4'b0100, 1'b0, rn, rd, 12'd1};
            end
         endcase
      end
   endtask

   // Compare on every edge and step the model on commits
   always @(posedge clk) begin
      dmemReq_t expReq;
      if (!reset) begin
         checkPc = mPc;
         checkValue("pc", mPc, pc);
         if (pcReady) begin
            expReq = stepModel(imem[checkPc[8:2]]);
            checkValue("strobe", word_t'(expReq.strobe), word_t'(dmemReq.strobe));
            checkValue("write", word_t'(expReq.write), word_t'(dmemReq.write));
            if (expReq.strobe) checkValue("addr", expReq.addr, dmemReq.addr);
            if (expReq.write) checkValue("writeData", expReq.writeData, dmemReq.writeData);
            if (checkPc == word_t'((ProgLen - 1) * 4)) loopHits++;
         end else begin
            checkValue("stall strobe", '0, word_t'(dmemReq.strobe));
            checkValue("stall write", '0, word_t'(dmemReq.write));
         end
      end
   end

   initial begin
      reset   = 1'b1;
      pcReady = 1'b0;
      void'($urandom(32'hdc804b83));
      for (int i = 0; i < 64; i++) begin
         dmem[i] = 32'h5A5A0000 ^ (i * 32'h01010101);
         mMem[i] = 32'h5A5A0000 ^ (i * 32'h01010101);
      end
      genProgram();
      repeat (4) @(negedge clk);
      reset = 1'b0;
      forever @(negedge clk) pcReady = ($urandom % 4) != 0;   // About 75% ready
   end

   // A failed port assertion ends the run at once
   initial begin
      wait (dut.props.failures != 0);
      $display("Port assertion failed near pc %h", pc);
      $display("TEST FAILED");
      $fatal(1, "Assertion failure");
   end

   initial begin
      wait (loopHits >= 3);
      @(negedge clk);
      if (dut.props.failures == 0) begin
         $display("TEST PASSED");
         $finish;
      end else begin
         $display("Port assertions failed %0d times", dut.props.failures);
         $display("TEST FAILED");
         $fatal(1, "Assertion failures");
      end
   end

   initial begin
      #(ProgLen * 8 * Period);
      $display("Timeout: program did not reach its final loop");
      $display("TEST FAILED");
      $fatal(1, "Watchdog expired");
   end

endmodule

// ==== build.f ====
+incdir+common
common/arm_pkg.sv
control/instrDecoder.sv
control/condUnit.sv
datapath/alu.sv
datapath/regFile.sv
datapath/datapath.sv
rtl/armCore.sv
test/armCore_properties.sv
test/armCore_tb.sv

// ==== Bender.yml ====
package:
  name: arm_core

sources:
  - include_dirs:
      - common
    files:
      - common/arm_pkg.sv
      - control/instrDecoder.sv
      - control/condUnit.sv
      - datapath/alu.sv
      - datapath/regFile.sv
      - datapath/datapath.sv
      - rtl/armCore.sv
  - target: test
    include_dirs:
      - common
    files:
      - test/armCore_properties.sv
      - test/armCore_tb.sv
